//--- source/pcs_pkg.sv
package pcs_pkg;

    // ======================================================================
    // GPIO word layout
    // ======================================================================
    localparam int GPIO_WIDTH   = 32;
    localparam int OPCODE_WIDTH = 9;                  // bits 30..22, bit 31 is the strobe
    localparam int FIELD_WIDTH  = 22;                 // bits 21..0
    localparam int STROBE_BIT   = GPIO_WIDTH - 1;

    localparam logic [OPCODE_WIDTH-1:0] OP_TEST   = 9'd0;
    localparam logic [OPCODE_WIDTH-1:0] OP_ENABLE = 9'd1;
    localparam logic [OPCODE_WIDTH-1:0] OP_READ   = 9'd2;

    // bit positions inside the enable field
    localparam int N_BLOCKS       = 5;
    localparam int EN_ENCODER     = 0;
    localparam int EN_SCRAMBLER   = 1;
    localparam int EN_DESCRAMBLER = 2;
    localparam int EN_DECODER     = 3;
    localparam int EN_CAPTURE     = 4;

    // ======================================================================
    // data path
    // ======================================================================
    localparam int         BLOCK_WIDTH  = 64;
    localparam int         HEADER_WIDTH = 2;
    localparam logic [1:0] SYNC_DATA    = 2'b01;
    localparam logic [1:0] SYNC_CTRL    = 2'b10;      // legal on the line, never generated here

    localparam int SCR_TAP_NEAR = 39;                 // 1 + x^39 + x^58
    localparam int SCR_TAP_FAR  = 58;

    localparam int LOCK_COUNT = 4;

    localparam int RAM_ADDR_WIDTH = 5;
    localparam int RAM_DEPTH      = 1 << RAM_ADDR_WIDTH;
    localparam int COUNT_WIDTH    = RAM_ADDR_WIDTH + 1;
    localparam int READ_HIGH_BIT  = RAM_ADDR_WIDTH;   // half-select sits just above the address

    typedef struct packed {
        logic capture;
        logic decoder;
        logic descrambler;
        logic scrambler;
        logic encoder;
    } enables_t;

    typedef struct packed {
        logic                    valid;
        logic [HEADER_WIDTH-1:0] header;
        logic [BLOCK_WIDTH-1:0]  payload;
    } block66_t;

    typedef struct packed {
        logic                   valid;
        logic [BLOCK_WIDTH-1:0] data;
    } word64_t;

endpackage

//--- source/gpio_register_file.sv
`timescale 1ns/10ps

module gpio_register_file
    import pcs_pkg::*;
    (
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic [GPIO_WIDTH-1:0]     i_gpio_in,

    output enables_t                  o_enables,
    output logic [FIELD_WIDTH-1:0]    o_seed,
    output logic [RAM_ADDR_WIDTH-1:0] o_read_address,
    output logic                      o_read_high,
    output logic                      o_restart
    );

logic                    strobe;
logic [OPCODE_WIDTH-1:0] opcode;
logic [FIELD_WIDTH-1:0]  field;
logic [N_BLOCKS-1:0]     enable_field;
enables_t                field_enables;

assign strobe       = i_gpio_in[STROBE_BIT];
assign opcode       = i_gpio_in[STROBE_BIT-1 -: OPCODE_WIDTH];
assign field        = i_gpio_in[FIELD_WIDTH-1:0];
assign enable_field = field[N_BLOCKS-1:0];

// map the field bits onto the named enables
always_comb
begin
    field_enables.encoder     = enable_field[EN_ENCODER];
    field_enables.scrambler   = enable_field[EN_SCRAMBLER];
    field_enables.descrambler = enable_field[EN_DESCRAMBLER];
    field_enables.decoder     = enable_field[EN_DECODER];
    field_enables.capture     = enable_field[EN_CAPTURE];
end

// ======================================================================
// opcode decode, acts on every cycle with the strobe high
// ======================================================================
always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        o_enables      <= '0;
        o_seed         <= '0;
        o_read_address <= '0;
        o_read_high    <= 1'b0;
        o_restart      <= 1'b0;
    end
    else
    begin
        o_restart <= 1'b0;                            // single pulse unless the word is held
        if (strobe)
        begin
            case (opcode)
                OP_TEST:
                begin
                    o_enables <= field_enables;
                    o_seed    <= field;
                    o_restart <= 1'b1;
                end
                OP_ENABLE:
                begin
                    o_enables <= field_enables;
                end
                OP_READ:
                begin
                    o_read_address <= field[RAM_ADDR_WIDTH-1:0];
                    o_read_high    <= field[READ_HIGH_BIT];
                end
                default: ;                            // unknown opcodes are ignored
            endcase
        end
    end
end

endmodule

//--- source/pattern_source.sv
`timescale 1ns/10ps

module pattern_source
    import pcs_pkg::*;
    (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_enable,
    input  logic                   i_restart,
    input  logic [FIELD_WIDTH-1:0] i_seed,

    output word64_t                o_word
    );

logic [BLOCK_WIDTH-1:0] count;
logic [BLOCK_WIDTH-1:0] seed_extended;

assign seed_extended = {{(BLOCK_WIDTH-FIELD_WIDTH){1'b0}}, i_seed};

always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        count        <= '0;
        o_word.valid <= 1'b0;
    end
    else if (i_restart)
    begin
        // the restart cycle emits nothing, the seed leaves on the next one
        count        <= seed_extended;
        o_word.valid <= 1'b0;
    end
    else
    begin
        o_word.valid <= i_enable;
        if (i_enable)
            count <= count + 1'b1;                    // next value waits while gated
    end
end

// data register follows the counter, qualified by valid
always_ff @(posedge i_clock)
begin
    o_word.data <= count;
end

endmodule

//--- source/block_encoder.sv
`timescale 1ns/10ps

module block_encoder
    import pcs_pkg::*;
    (
    input  logic     i_clock,
    input  logic     i_reset,
    input  word64_t  i_word,

    output block66_t o_block
    );

logic [HEADER_WIDTH-1:0] header;

// only data blocks exist on this path, idle slots carry an empty header
assign header = i_word.valid ? SYNC_DATA : '0;

always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        o_block.valid <= 1'b0;
    end
    else
    begin
        o_block.valid <= i_word.valid;
    end
end

always_ff @(posedge i_clock)
begin
    o_block.header  <= header;
    o_block.payload <= i_word.data;
end

endmodule

//--- source/scrambler.sv
`timescale 1ns/10ps

module scrambler
    import pcs_pkg::*;
    #(
    parameter int DESCRAMBLE = 0                      // 0 scrambles, 1 descrambles
    )
    (
    input  logic     i_clock,
    input  logic     i_reset,
    input  logic     i_enable,
    input  block66_t i_block,

    output block66_t o_block
    );

localparam int HISTORY_WIDTH = SCR_TAP_FAR;

logic [HISTORY_WIDTH-1:0] history;                    // bit 0 is the most recent line bit
logic [HISTORY_WIDTH-1:0] next_history;
logic [BLOCK_WIDTH-1:0]   next_payload;
logic                     mixed_bit;
logic                     feedback_bit;

// ======================================================================
// bit-serial recurrence unrolled over the payload, bit 0 goes first
// ======================================================================
always_comb
begin
    next_history = history;
    mixed_bit    = 1'b0;
    feedback_bit = 1'b0;
    for (int i = 0; i < BLOCK_WIDTH; i++)
    begin
        mixed_bit = i_block.payload[i]
                    ^ next_history[SCR_TAP_NEAR-1]
                    ^ next_history[SCR_TAP_FAR-1];
        next_payload[i] = i_enable ? mixed_bit : i_block.payload[i];
        // scrambler feeds back what it sends, descrambler what it receives
        if (DESCRAMBLE != 0)
            feedback_bit = i_block.payload[i];
        else
            feedback_bit = next_payload[i];
        next_history = {next_history[HISTORY_WIDTH-2:0], feedback_bit};
    end
end

always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        history       <= '0;
        o_block.valid <= 1'b0;
    end
    else
    begin
        o_block.valid <= i_block.valid;
        if (i_block.valid)
            history <= next_history;                  // idle slots leave the history alone
    end
end

// sync header is never scrambled
always_ff @(posedge i_clock)
begin
    o_block.header  <= i_block.header;
    o_block.payload <= next_payload;
end

endmodule

//--- source/block_decoder.sv
`timescale 1ns/10ps

module block_decoder
    import pcs_pkg::*;
    (
    input  logic     i_clock,
    input  logic     i_reset,
    input  logic     i_enable,
    input  block66_t i_block,

    output word64_t  o_word,
    output logic     o_lock
    );

localparam int LOCK_WIDTH = $clog2(LOCK_COUNT + 1);

logic [LOCK_WIDTH-1:0] good_count;
logic                  header_legal;

assign header_legal = (i_block.header == SYNC_DATA) || (i_block.header == SYNC_CTRL);

// block lock runs on every valid block, whatever the enable says
always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        good_count <= '0;
        o_lock     <= 1'b0;
    end
    else if (i_block.valid)
    begin
        if (header_legal)
        begin
            if (good_count < LOCK_COUNT)
                good_count <= good_count + 1'b1;
            if (good_count >= LOCK_COUNT - 1)
                o_lock <= 1'b1;
        end
        else
        begin
            good_count <= '0;                         // one bad header drops lock
            o_lock     <= 1'b0;
        end
    end
end

always_ff @(posedge i_clock)
begin
    if (i_reset)
        o_word.valid <= 1'b0;
    else
        o_word.valid <= i_block.valid && i_enable;
end

always_ff @(posedge i_clock)
begin
    o_word.data <= i_block.payload;
end

endmodule

//--- source/capture_ram.sv
`timescale 1ns/10ps

module capture_ram
    import pcs_pkg::*;
    (
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_enable,
    input  logic                      i_restart,
    input  word64_t                   i_word,
    input  logic [RAM_ADDR_WIDTH-1:0] i_read_address,
    input  logic                      i_read_high,

    output logic [GPIO_WIDTH-1:0]     o_read_data,
    output logic [COUNT_WIDTH-1:0]    o_count
    );

logic [BLOCK_WIDTH-1:0]    mem [RAM_DEPTH];
logic [RAM_ADDR_WIDTH-1:0] write_pointer;
logic [RAM_ADDR_WIDTH-1:0] read_address_q;
logic                      read_high_q;
logic                      full;
logic                      write_enable;

assign full         = (o_count == COUNT_WIDTH'(RAM_DEPTH));
assign write_enable = i_enable && i_word.valid && !full;   // extra words are dropped

// ======================================================================
// write side
// ======================================================================
always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        for (int i = 0; i < RAM_DEPTH; i++)
            mem[i] <= '0;                             // readback of an empty RAM gives zero
        write_pointer <= '0;
        o_count       <= '0;
    end
    else if (i_restart)
    begin
        write_pointer <= '0;
        o_count       <= '0;
    end
    else if (write_enable)
    begin
        mem[write_pointer] <= i_word.data;
        write_pointer      <= write_pointer + 1'b1;
        o_count            <= o_count + 1'b1;
    end
end

// read side is two registers deep, address then data
always_ff @(posedge i_clock)
begin
    if (i_reset)
    begin
        read_address_q <= '0;
        read_high_q    <= 1'b0;
        o_read_data    <= '0;
    end
    else
    begin
        read_address_q <= i_read_address;
        read_high_q    <= i_read_high;
        if (read_high_q)
            o_read_data <= mem[read_address_q][BLOCK_WIDTH-1 -: GPIO_WIDTH];
        else
            o_read_data <= mem[read_address_q][GPIO_WIDTH-1:0];
    end
end

endmodule

//--- source/pcs_loopback_top.sv
`timescale 1ns/10ps

module pcs_loopback_top
    import pcs_pkg::*;
    (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic [GPIO_WIDTH-1:0]  i_gpio_in,

    output logic [GPIO_WIDTH-1:0]  o_gpio_out,
    output logic                   o_lock,
    output logic [COUNT_WIDTH-1:0] o_capture_count
    );

enables_t                  enables;
logic [FIELD_WIDTH-1:0]    seed;
logic [RAM_ADDR_WIDTH-1:0] read_address;
logic                      read_high;
logic                      restart;

word64_t                   source_word;
block66_t                  encoded_block;
block66_t                  scrambled_block;
block66_t                  descrambled_block;
word64_t                   decoded_word;

// ======================================================================
// control
// ======================================================================
gpio_register_file u_gpio_register_file (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_gpio_in      (i_gpio_in),
    .o_enables      (enables),
    .o_seed         (seed),
    .o_read_address (read_address),
    .o_read_high    (read_high),
    .o_restart      (restart)
);

// ======================================================================
// data path, one register per stage
// ======================================================================
pattern_source u_pattern_source (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_enable  (enables.encoder),                     // the encoder bit gates the source
    .i_restart (restart),
    .i_seed    (seed),
    .o_word    (source_word)
);

block_encoder u_block_encoder (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_word  (source_word),
    .o_block (encoded_block)
);

scrambler #(
    .DESCRAMBLE (0)
) u_scrambler (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_enable (enables.scrambler),
    .i_block  (encoded_block),
    .o_block  (scrambled_block)
);

scrambler #(
    .DESCRAMBLE (1)
) u_descrambler (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_enable (enables.descrambler),
    .i_block  (scrambled_block),
    .o_block  (descrambled_block)
);

block_decoder u_block_decoder (
    .i_clock  (i_clock),
    .i_reset  (i_reset),
    .i_enable (enables.decoder),
    .i_block  (descrambled_block),
    .o_word   (decoded_word),
    .o_lock   (o_lock)
);

capture_ram u_capture_ram (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_enable       (enables.capture),
    .i_restart      (restart),
    .i_word         (decoded_word),
    .i_read_address (read_address),
    .i_read_high    (read_high),
    .o_read_data    (o_gpio_out),
    .o_count        (o_capture_count)
);

endmodule

//--- sim/pcs_loopback_assert.sv
`timescale 1ns/10ps

module pcs_loopback_assert
    import pcs_pkg::*;
    (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  enables_t               i_enables,
    input  logic                   i_restart,
    input  logic                   i_lock,
    input  logic [COUNT_WIDTH-1:0] i_capture_count,
    input  logic                   i_source_valid,
    input  logic                   i_decoded_valid,
    input  block66_t               i_block
    );

logic bad_header;

// a valid block whose header is neither data nor control
assign bad_header = i_block.valid
                    && !((i_block.header == SYNC_DATA) || (i_block.header == SYNC_CTRL));

// ======================================================================
// control state
// ======================================================================
reset_state: assert property (@(posedge i_clock)
    $fell(i_reset) |-> ((i_enables == '0) && !i_lock))
    else $error("enables or lock not cleared by reset");

count_bound: assert property (@(posedge i_clock) disable iff (i_reset)
    i_capture_count <= COUNT_WIDTH'(RAM_DEPTH))
    else $error("capture count above the RAM depth");

count_monotonic: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_capture_count < $past(i_capture_count)) |-> $past(i_restart))
    else $error("capture count fell without a restart");

// ======================================================================
// data path
// ======================================================================
// encoder, scrambler, descrambler and decoder each add one cycle
path_latency: assert property (@(posedge i_clock) disable iff (i_reset)
    ($past(i_source_valid, 4) && ($past(i_enables) == 5'b11111)) |-> i_decoded_valid)
    else $error("source word did not reach the decoder output four cycles later");

lock_holds: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_lock && !bad_header) |=> i_lock)
    else $error("block lock dropped with only legal headers arriving");

endmodule

bind pcs_loopback_top pcs_loopback_assert u_assert (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_enables       (enables),
    .i_restart       (restart),
    .i_lock          (o_lock),
    .i_capture_count (o_capture_count),
    .i_source_valid  (source_word.valid),
    .i_decoded_valid (decoded_word.valid),
    .i_block         (descrambled_block)
);

//--- sim/pcs_loopback_tb.sv
`timescale 1ns/10ps

module pcs_loopback_tb
    import pcs_pkg::*;
    ();

localparam int CLOCK_PERIOD    = 10;
localparam int RESET_CYCLES    = 5;
localparam int READ_CYCLES     = 3;                  // read word plus two cycles of latency
localparam int FILL_CYCLES     = 100;
localparam int SETUP_CYCLES    = 120;
localparam int TEST_CYCLES     = 3 * (2 * RAM_DEPTH * READ_CYCLES + FILL_CYCLES) + SETUP_CYCLES;
localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

// the low five seed bits double as the enable field of OP_TEST
localparam logic [N_BLOCKS-1:0] ALL_ON     = 5'b11111;
localparam logic [N_BLOCKS-1:0] SOURCE_OFF = 5'b11110;
localparam logic [N_BLOCKS-1:0] BYPASS     = 5'b11001;

logic                   clock;
logic                   reset;
logic [GPIO_WIDTH-1:0]  gpio_in;
logic [GPIO_WIDTH-1:0]  gpio_out;
logic                   lock;
logic [COUNT_WIDTH-1:0] capture_count;
logic [FIELD_WIDTH-1:0] seed;
logic [COUNT_WIDTH-1:0] held_count;

pcs_loopback_top u_dut (
    .i_clock         (clock),
    .i_reset         (reset),
    .i_gpio_in       (gpio_in),
    .o_gpio_out      (gpio_out),
    .o_lock          (lock),
    .o_capture_count (capture_count)
);

initial
begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
end

initial
begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("** FAIL **");
    $fatal(1, "watchdog expired before the tests finished");
end

function automatic logic [GPIO_WIDTH-1:0] gpio_word(input logic [OPCODE_WIDTH-1:0] opcode,
                                                    input logic [FIELD_WIDTH-1:0] field);
    return {1'b1, opcode, field};                    // strobe in bit 31
endfunction

// captured entry i holds seed + i
function automatic logic [GPIO_WIDTH-1:0] expected_half(input logic [FIELD_WIDTH-1:0] base,
                                                        input int index, input logic high);
    logic [BLOCK_WIDTH-1:0] value;
    value = BLOCK_WIDTH'(base) + BLOCK_WIDTH'(index);
    return high ? value[BLOCK_WIDTH-1 -: GPIO_WIDTH] : value[GPIO_WIDTH-1:0];
endfunction

task automatic check_value(input string name, input logic [BLOCK_WIDTH-1:0] expected,
                           input logic [BLOCK_WIDTH-1:0] actual);
    assert (actual === expected)
    else
    begin
        $display("FAIL at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "%s mismatch", name);
    end
endtask

// one strobed cycle, then the bus goes quiet
task automatic apply_word(input logic [GPIO_WIDTH-1:0] word);
    gpio_in = word;
    @(negedge clock);
    gpio_in = '0;
endtask

task automatic start_test(input logic [N_BLOCKS-1:0] enables);
    seed = {(FIELD_WIDTH-N_BLOCKS)'($urandom()), enables};
    apply_word(gpio_word(OP_TEST, seed));
    repeat (2) @(negedge clock);                     // restart has cleared the count
endtask

task automatic wait_for_full();
    while (capture_count != COUNT_WIDTH'(RAM_DEPTH))
        @(negedge clock);
endtask

task automatic drain_pipeline();
    apply_word(gpio_word(OP_ENABLE, FIELD_WIDTH'(SOURCE_OFF)));
    repeat (8) @(negedge clock);
endtask

// output must hold through edge n+1 and change after edge n+2
task automatic read_half(input int address, input logic high,
                         input logic [GPIO_WIDTH-1:0] expected);
    logic [GPIO_WIDTH-1:0] previous;
    previous = gpio_out;
    apply_word(gpio_word(OP_READ, {16'd0, high, address[RAM_ADDR_WIDTH-1:0]}));
    @(negedge clock);
    check_value("o_gpio_out", BLOCK_WIDTH'(previous), BLOCK_WIDTH'(gpio_out));
    @(negedge clock);
    check_value("o_gpio_out", BLOCK_WIDTH'(expected), BLOCK_WIDTH'(gpio_out));
endtask

task automatic compare_capture(input logic [FIELD_WIDTH-1:0] base);
    for (int i = 0; i < RAM_DEPTH; i++)
    begin
        read_half(i, 1'b0, expected_half(base, i, 1'b0));
        read_half(i, 1'b1, expected_half(base, i, 1'b1));
    end
endtask

// ======================================================================
// test sequence
// ======================================================================
initial
begin
    void'($urandom(40));
    reset      = 1'b1;
    gpio_in    = '0;
    seed       = '0;
    held_count = '0;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    check_value("o_gpio_out", '0, BLOCK_WIDTH'(gpio_out));
    check_value("o_lock", '0, BLOCK_WIDTH'(lock));
    check_value("o_capture_count", '0, BLOCK_WIDTH'(capture_count));
    read_half(0, 1'b0, '0);
    read_half(17, 1'b1, '0);
    read_half(31, 1'b0, '0);
    read_half(31, 1'b1, '0);

    // full loopback, words past the 32nd are dropped
    start_test(ALL_ON);
    wait_for_full();
    repeat (10) @(negedge clock);
    check_value("o_capture_count", BLOCK_WIDTH'(RAM_DEPTH), BLOCK_WIDTH'(capture_count));
    check_value("o_lock", 1, BLOCK_WIDTH'(lock));
    compare_capture(seed);

    // both scramblers in bypass
    drain_pipeline();
    start_test(BYPASS);
    wait_for_full();
    check_value("o_lock", 1, BLOCK_WIDTH'(lock));
    compare_capture(seed);

    // gate the source halfway through a fill
    drain_pipeline();
    start_test(ALL_ON);
    while (capture_count < COUNT_WIDTH'(12))
        @(negedge clock);
    apply_word(gpio_word(OP_ENABLE, FIELD_WIDTH'(SOURCE_OFF)));
    repeat (8) @(negedge clock);                     // words in flight still land
    held_count = capture_count;
    repeat (20) @(negedge clock);
    check_value("o_capture_count", BLOCK_WIDTH'(held_count), BLOCK_WIDTH'(capture_count));
    apply_word(gpio_word(OP_ENABLE, FIELD_WIDTH'(ALL_ON)));
    wait_for_full();
    compare_capture(seed);

    $display("** PASS **");
    $finish;
end

endmodule

//--- project.f
source/pcs_pkg.sv
source/gpio_register_file.sv
source/pattern_source.sv
source/block_encoder.sv
source/scrambler.sv
source/block_decoder.sv
source/capture_ram.sv
source/pcs_loopback_top.sv
sim/pcs_loopback_assert.sv
sim/pcs_loopback_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the loopback testbench with Verilator and runs it
# the exit status is nonzero when the build fails or the simulation stops on $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module pcs_loopback_tb \
    -o pcs_loopback_sim &&
./obj_dir/pcs_loopback_sim ||
{ echo "simulation failed"; exit 1; }
